/* md_arbiter_pkg.sv */
/*
 * bus widths, 68000 and Z80 address map constants,
 * and the union over the upper 68000 address
 */
package md_arbiter_pkg;

	// bus widths
	parameter int VA_W       = 23;
	parameter int ZA_W       = 16;
	parameter int BANK_W_DEF = 9;

	// z80 side map
	parameter logic [7:0] ZBANK_PAGE = 8'h60;
	parameter logic [1:0] ZRAM_TOP   = 2'b00;
	parameter logic [2:0] SOUND_TOP  = 3'b010;

	// 68000 pages, A23..A16
	parameter logic [7:0] IO_PAGE_Z80 = 8'ha0;
	parameter logic [7:0] IO_PAGE_REG = 8'ha1;

	// sub-pages of A1xxxx, A15..A8
	parameter logic [7:0] REG_IO     = 8'h00;
	parameter logic [7:0] REG_BUSREQ = 8'h11;
	parameter logic [7:0] REG_ZRESET = 8'h12;
	parameter logic [7:0] REG_FDC    = 8'h20;
	parameter logic [7:0] REG_TIME   = 8'h30;

	// VDP lives at C00000..DFFFFF
	parameter logic [2:0] VDP_TOP = 3'b110;

	// bit positions in the one-hot control select
	parameter int SEL_BUSREQ = 0;
	parameter int SEL_ZRESET = 1;

	// A23..A8 as one word for region tests, or as page and sub-page
	typedef union packed
	{
		logic [15:0]     flat;
		logic [1:0][7:0] io;
	} cpu_page_u;

endpackage

/* md_addr_decode.sv */
/*
 * chip-select decoding for the 68000 and Z80 buses,
 * control register select and bank write strobe
 */
`timescale 1ns/1ps

module md_addr_decode
(
	input  logic [md_arbiter_pkg::VA_W-1:0] va_i,
	input  logic                            as_n_i,
	input  logic [md_arbiter_pkg::ZA_W-1:0] za_i,
	input  logic                            zwr_n_i,
	input  logic                            cart_i,
	output logic                            rom_cs_n_o,
	output logic                            vz_n_o,
	output logic                            io_cs_n_o,
	output logic                            fdc_cs_n_o,
	output logic                            time_n_o,
	output logic                            vdp_cs_n_o,
	output logic                            zram_cs_n_o,
	output logic                            sound_cs_n_o,
	output logic [1:0]                      ctrl_sel_o,
	output logic                            zbank_we_o
);
	import md_arbiter_pkg::*;

	cpu_page_u page;
	logic      as_act;
	logic      reg_page;
	logic      rom_hit;
	logic      vz_hit;
	logic      vdp_hit;
	logic      io_hit;
	logic      busreq_hit;
	logic      zreset_hit;
	logic      fdc_hit;
	logic      time_hit;

	assign page.flat = va_i[VA_W-1:VA_W-16];
	assign as_act    = ~as_n_i;

	// cartridge swap, the ROM half follows the inverted cart line
	assign rom_hit = ~page.flat[15] & (page.flat[14] == ~cart_i);
	assign vdp_hit = page.flat[15:13] == VDP_TOP;

	assign vz_hit   = page.io[1] == IO_PAGE_Z80;
	assign reg_page = page.io[1] == IO_PAGE_REG;

	assign io_hit     = reg_page & (page.io[0] == REG_IO);
	assign busreq_hit = reg_page & (page.io[0] == REG_BUSREQ);
	assign zreset_hit = reg_page & (page.io[0] == REG_ZRESET);
	assign fdc_hit    = reg_page & (page.io[0] == REG_FDC);
	assign time_hit   = reg_page & (page.io[0] == REG_TIME);

	// 68000 selects, active low, only during AS
	assign rom_cs_n_o = ~(as_act & rom_hit);
	assign vz_n_o     = ~(as_act & vz_hit);
	assign io_cs_n_o  = ~(as_act & io_hit);
	assign fdc_cs_n_o = ~(as_act & fdc_hit);
	assign time_n_o   = ~(as_act & time_hit);
	assign vdp_cs_n_o = ~(as_act & vdp_hit);

	assign ctrl_sel_o[SEL_BUSREQ] = as_act & busreq_hit;
	assign ctrl_sel_o[SEL_ZRESET] = as_act & zreset_hit;

	// z80 side
	assign zram_cs_n_o  = ~(za_i[ZA_W-1:ZA_W-2] == ZRAM_TOP);
	assign sound_cs_n_o = ~(za_i[ZA_W-1:ZA_W-3] == SOUND_TOP);

	// one bank bit per write to 6000..60ff
	assign zbank_we_o = ~zwr_n_i & (za_i[ZA_W-1:ZA_W-8] == ZBANK_PAGE);

endmodule

/* md_z80_bank.sv */
/*
 * Z80 bank register, loaded one bit per write from data bit 0
 */
`timescale 1ns/1ps

module md_z80_bank
#(
	parameter int BANK_W = md_arbiter_pkg::BANK_W_DEF
)
(
	input  logic              MCLK,
	input  logic              arst_n_i,
	input  logic              zbank_we_i,
	input  logic              zd0_i,
	output logic [BANK_W-1:0] bank_o
);

	// new bit enters at the top, so the last write lands in the msb
	always_ff @(posedge MCLK or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			bank_o <= '0;
		end
		else if (zbank_we_i)
		begin
			bank_o <= {zd0_i, bank_o[BANK_W-1:1]};
		end
	end

endmodule

/* md_ctrl_regs.sv */
/*
 * Z80 bus-request and Z80 reset registers written by the 68000
 */
`timescale 1ns/1ps

module md_ctrl_regs
(
	input  logic       MCLK,
	input  logic       arst_n_i,
	input  logic [1:0] ctrl_sel_i,
	input  logic       rw_i,
	input  logic       uds_n_i,
	input  logic       vd8_i,
	output logic       zbr_n_o,
	output logic       zres_n_o
);
	import md_arbiter_pkg::*;

	logic wr_en;
	logic busreq_q;
	logic zrun_q;

	// upper byte write, data arrives on D8
	assign wr_en = ~rw_i & ~uds_n_i;

	always_ff @(posedge MCLK or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			busreq_q <= 1'b0;
			zrun_q   <= 1'b0;
		end
		else
		begin
			if (wr_en & ctrl_sel_i[SEL_BUSREQ])
			begin
				busreq_q <= vd8_i;
			end
			if (wr_en & ctrl_sel_i[SEL_ZRESET])
			begin
				zrun_q <= vd8_i;
			end
		end
	end

	assign zbr_n_o = ~busreq_q;

	// 0 keeps the z80 in reset
	assign zres_n_o = zrun_q;

endmodule

/* md_bus_bridge.sv */
/*
 * Z80 bank window bridge, takes the 68000 bus and runs one
 * 68000 cycle per window request
 */
`timescale 1ns/1ps

module md_bus_bridge
#(
	parameter int BANK_W = md_arbiter_pkg::BANK_W_DEF
)
(
	input  logic                            MCLK,
	input  logic                            arst_n_i,
	input  logic                            z_req_i,
	input  logic                            z_we_i,
	input  logic [md_arbiter_pkg::ZA_W-1:0] za_i,
	input  logic [BANK_W-1:0]               bank_i,
	output logic                            z_ack_o,
	input  logic                            bg_n_i,
	input  logic                            as_n_i,
	input  logic                            dtack_n_i,
	output logic                            br_n_o,
	output logic                            bgack_n_o,
	output logic [md_arbiter_pkg::VA_W-1:0] va_o,
	output logic                            as_n_o,
	output logic                            uds_n_o,
	output logic                            lds_n_o,
	output logic                            rw_o
);
	import md_arbiter_pkg::*;

	localparam logic [2:0] ST_IDLE   = 3'd0;
	localparam logic [2:0] ST_REQ    = 3'd1;
	localparam logic [2:0] ST_GRANT  = 3'd2;
	localparam logic [2:0] ST_STROBE = 3'd3;
	localparam logic [2:0] ST_WAIT   = 3'd4;
	localparam logic [2:0] ST_ACK    = 3'd5;

	logic [2:0]      state_q;
	logic [2:0]      state_d;
	logic [VA_W-1:0] addr_q;
	logic            rw_q;
	logic            odd_q;
	logic            start;
	logic            own;
	logic            strobe;

	// window is 8000..ffff of the z80 map
	assign start = z_req_i & za_i[ZA_W-1];

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:
			begin
				if (start)
				begin
					state_d = ST_REQ;
				end
			end
			ST_REQ:
			begin
				// bus is ours once granted and the current cycle has ended
				if (!bg_n_i && as_n_i)
				begin
					state_d = ST_GRANT;
				end
			end
			ST_GRANT:  state_d = ST_STROBE;
			ST_STROBE: state_d = ST_WAIT;
			ST_WAIT:
			begin
				if (!dtack_n_i)
				begin
					state_d = ST_ACK;
				end
			end
			ST_ACK:
			begin
				if (!z_req_i)
				begin
					state_d = ST_IDLE;
				end
			end
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge MCLK or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q <= ST_IDLE;
		end
		else
		begin
			state_q <= state_d;
		end
	end

	// address and direction held for the whole 68000 cycle
	always_ff @(posedge MCLK)
	begin
		if (state_q == ST_IDLE && start)
		begin
			addr_q <= {bank_i, za_i[ZA_W-2:1]};
			rw_q   <= ~z_we_i;
			odd_q  <= za_i[0];
		end
	end

	assign own    = (state_q == ST_GRANT) || (state_q == ST_STROBE) || (state_q == ST_WAIT);
	assign strobe = (state_q == ST_STROBE) || (state_q == ST_WAIT);

	assign br_n_o    = state_q != ST_REQ;
	assign bgack_n_o = ~own;
	assign as_n_o    = ~strobe;
	assign uds_n_o   = ~(strobe & ~odd_q);
	assign lds_n_o   = ~(strobe & odd_q);
	// read level whenever the bus is not ours
	assign rw_o      = ~own | rw_q;
	assign va_o      = addr_q;
	assign z_ack_o   = state_q == ST_ACK;

endmodule

/* md_arbiter.sv */
/*
 * bus arbiter top, address decode, Z80 bank, control registers
 * and the window bridge
 */
`timescale 1ns/1ps

module md_arbiter
#(
	parameter int BANK_W = md_arbiter_pkg::BANK_W_DEF
)
(
	input  logic                            MCLK,
	input  logic                            arst_n_i,
	input  logic [md_arbiter_pkg::VA_W-1:0] va_i,
	input  logic                            as_n_i,
	input  logic                            uds_n_i,
	input  logic                            rw_i,
	input  logic                            vd8_i,
	input  logic                            dtack_n_i,
	input  logic                            bg_n_i,
	input  logic                            cart_i,
	input  logic [md_arbiter_pkg::ZA_W-1:0] za_i,
	input  logic                            zwr_n_i,
	input  logic                            zd0_i,
	input  logic                            zbak_n_i,
	input  logic                            z_req_i,
	input  logic                            z_we_i,
	output logic                            rom_cs_n_o,
	output logic                            vz_n_o,
	output logic                            io_cs_n_o,
	output logic                            fdc_cs_n_o,
	output logic                            time_n_o,
	output logic                            vdp_cs_n_o,
	output logic                            zram_cs_n_o,
	output logic                            sound_cs_n_o,
	output logic                            zbr_n_o,
	output logic                            zres_n_o,
	output logic                            vd8_o,
	output logic                            br_n_o,
	output logic                            bgack_n_o,
	output logic [md_arbiter_pkg::VA_W-1:0] va_o,
	output logic                            as_n_o,
	output logic                            uds_n_o,
	output logic                            lds_n_o,
	output logic                            rw_o,
	output logic                            z_ack_o
);

	logic [1:0]        ctrl_sel;
	logic              zbank_we;
	logic [BANK_W-1:0] bank_q;

	md_addr_decode u_decode
	(
		.va_i         (va_i),
		.as_n_i       (as_n_i),
		.za_i         (za_i),
		.zwr_n_i      (zwr_n_i),
		.cart_i       (cart_i),
		.rom_cs_n_o   (rom_cs_n_o),
		.vz_n_o       (vz_n_o),
		.io_cs_n_o    (io_cs_n_o),
		.fdc_cs_n_o   (fdc_cs_n_o),
		.time_n_o     (time_n_o),
		.vdp_cs_n_o   (vdp_cs_n_o),
		.zram_cs_n_o  (zram_cs_n_o),
		.sound_cs_n_o (sound_cs_n_o),
		.ctrl_sel_o   (ctrl_sel),
		.zbank_we_o   (zbank_we)
	);

	md_z80_bank #(.BANK_W(BANK_W)) u_bank
	(
		.MCLK       (MCLK),
		.arst_n_i   (arst_n_i),
		.zbank_we_i (zbank_we),
		.zd0_i      (zd0_i),
		.bank_o     (bank_q)
	);

	md_ctrl_regs u_ctrl
	(
		.MCLK       (MCLK),
		.arst_n_i   (arst_n_i),
		.ctrl_sel_i (ctrl_sel),
		.rw_i       (rw_i),
		.uds_n_i    (uds_n_i),
		.vd8_i      (vd8_i),
		.zbr_n_o    (zbr_n_o),
		.zres_n_o   (zres_n_o)
	);

	md_bus_bridge #(.BANK_W(BANK_W)) u_bridge
	(
		.MCLK      (MCLK),
		.arst_n_i  (arst_n_i),
		.z_req_i   (z_req_i),
		.z_we_i    (z_we_i),
		.za_i      (za_i),
		.bank_i    (bank_q),
		.z_ack_o   (z_ack_o),
		.bg_n_i    (bg_n_i),
		.as_n_i    (as_n_i),
		.dtack_n_i (dtack_n_i),
		.br_n_o    (br_n_o),
		.bgack_n_o (bgack_n_o),
		.va_o      (va_o),
		.as_n_o    (as_n_o),
		.uds_n_o   (uds_n_o),
		.lds_n_o   (lds_n_o),
		.rw_o      (rw_o)
	);

	// bus acknowledge read back on D8
	assign vd8_o = zbak_n_i;

endmodule

/* tb_md_arbiter_assert.sv */
/*
 * bus ownership and window handshake properties for the bridge
 */
`timescale 1ns/1ps

module tb_md_arbiter_assert
(
	input logic MCLK,
	input logic arst_n_i,
	input logic z_req_i,
	input logic z_ack_o,
	input logic br_n_o,
	input logic bgack_n_o,
	input logic as_n_o
);

	// strobe only while we hold the bus
	as_needs_bgack: assert property (@(posedge MCLK) disable iff (!arst_n_i)
		!as_n_o |-> !bgack_n_o)
		else $error("as_n_o low without bgack_n_o");

	ack_needs_req: assert property (@(posedge MCLK) disable iff (!arst_n_i)
		$rose(z_ack_o) |-> z_req_i)
		else $error("z_ack_o rose without z_req_i");

	br_released: assert property (@(posedge MCLK) disable iff (!arst_n_i)
		(!br_n_o && !bgack_n_o) |=> !(!br_n_o && !bgack_n_o))
		else $error("br_n_o and bgack_n_o low together too long");

endmodule

bind md_bus_bridge tb_md_arbiter_assert u_assert
(
	.MCLK      (MCLK),
	.arst_n_i  (arst_n_i),
	.z_req_i   (z_req_i),
	.z_ack_o   (z_ack_o),
	.br_n_o    (br_n_o),
	.bgack_n_o (bgack_n_o),
	.as_n_o    (as_n_o)
);

/* tb_md_arbiter.sv */
/*
 * testbench for the bus arbiter, random stimulus, 68000 bus responder,
 * reference model of the address map, bank register and control bits
 */
`timescale 1ns/1ps

module tb_md_arbiter;

	logic        MCLK;
	logic        arst_n_i;
	logic [22:0] va_i;
	logic        as_n_i;
	logic        uds_n_i;
	logic        rw_i;
	logic        vd8_i;
	logic        dtack_n_i;
	logic        bg_n_i;
	logic        cart_i;
	logic [15:0] za_i;
	logic        zwr_n_i;
	logic        zd0_i;
	logic        zbak_n_i;
	logic        z_req_i;
	logic        z_we_i;
	logic        rom_cs_n_o;
	logic        vz_n_o;
	logic        io_cs_n_o;
	logic        fdc_cs_n_o;
	logic        time_n_o;
	logic        vdp_cs_n_o;
	logic        zram_cs_n_o;
	logic        sound_cs_n_o;
	logic        zbr_n_o;
	logic        zres_n_o;
	logic        vd8_o;
	logic        br_n_o;
	logic        bgack_n_o;
	logic [22:0] va_o;
	logic        as_n_o;
	logic        uds_n_o;
	logic        lds_n_o;
	logic        rw_o;
	logic        z_ack_o;

	integer      seed;
	integer      err_cnt;
	integer      chk_cnt;
	integer      to_cnt;
	logic [8:0]  bank_m;
	logic        busreq_m;
	logic        zrun_m;

	md_arbiter dut_i (.*);

	initial
	begin
		MCLK = 1'b0;
		forever #2 MCLK = ~MCLK;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		chk_cnt = chk_cnt + 1;
		if (got !== exp)
		begin
			err_cnt = err_cnt + 1;
			$display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
		end
	endtask

	// grant after br, dtack after as, each after 0..7 cycles
	initial
	begin : responder
		logic [31:0] r;
		forever
		begin
			@(posedge MCLK);
			if (!br_n_o && bg_n_i)
			begin
				r = $random(seed);
				repeat (r[2:0]) @(posedge MCLK);
				bg_n_i <= 1'b0;
			end
			else if (br_n_o && bgack_n_o)
			begin
				bg_n_i <= 1'b1;
			end
			if (!as_n_o && dtack_n_i)
			begin
				r = $random(seed);
				repeat (r[2:0]) @(posedge MCLK);
				dtack_n_i <= 1'b0;
			end
			else if (as_n_o)
			begin
				dtack_n_i <= 1'b1;
			end
		end
	end

	task automatic decode_round;
		logic [31:0] r;
		logic [31:0] s;
		logic [15:0] pg;
		logic        act;
		r = $random(seed);
		s = $random(seed);
		@(posedge MCLK);
		// steer half the addresses onto the interesting pages
		case (s[6:4])
			3'd0: pg = 16'ha000;
			3'd1: pg = 16'ha100;
			3'd2: pg = 16'ha120;
			3'd3: pg = 16'ha130;
			3'd4: pg = 16'hc000;
			3'd5: pg = 16'ha140;
			default: pg = r[22:7];
		endcase
		va_i    <= s[3] ? {pg, r[6:0]} : r[22:0];
		as_n_i  <= s[0];
		cart_i  <= s[1];
		uds_n_i <= s[2];
		rw_i    <= 1'b1;
		zwr_n_i <= 1'b1;
		za_i    <= s[31:16];
		@(negedge MCLK);
		pg  = va_i[22:7];
		act = ~as_n_i;
		check("rom_cs_n_o", 32'(rom_cs_n_o), 32'(!(act && !va_i[22] && (va_i[21] == !cart_i))));
		check("vz_n_o", 32'(vz_n_o), 32'(!(act && pg[15:8] == 8'ha0)));
		check("io_cs_n_o", 32'(io_cs_n_o), 32'(!(act && pg == 16'ha100)));
		check("fdc_cs_n_o", 32'(fdc_cs_n_o), 32'(!(act && pg == 16'ha120)));
		check("time_n_o", 32'(time_n_o), 32'(!(act && pg == 16'ha130)));
		check("vdp_cs_n_o", 32'(vdp_cs_n_o), 32'(!(act && va_i[22:20] == 3'b110)));
		check("zram_cs_n_o", 32'(zram_cs_n_o), 32'(!(za_i[15:14] == 2'b00)));
		check("sound_cs_n_o", 32'(sound_cs_n_o), 32'(!(za_i[15:13] == 3'b010)));
	endtask

	task automatic bank_load(input int n);
		logic [31:0] r;
		for (int k = 0; k < n; k++)
		begin
			r = $random(seed);
			@(posedge MCLK);
			za_i    <= {8'h60, r[7:0]};
			zwr_n_i <= 1'b0;
			zd0_i   <= r[8];
			bank_m = {r[8], bank_m[8:1]};
		end
		@(posedge MCLK);
		zwr_n_i <= 1'b1;
	endtask

	task automatic ctrl_round;
		logic [31:0] r;
		logic [15:0] pg;
		r = $random(seed);
		case (r[1:0])
			2'd0: pg = 16'ha111;
			2'd1: pg = 16'ha112;
			2'd2: pg = (r[31:16] == 16'ha111 || r[31:16] == 16'ha112) ? 16'ha113 : r[31:16];
			default: pg = r[11] ? 16'ha111 : 16'ha112;
		endcase
		@(posedge MCLK);
		va_i     <= {pg, r[8:2]};
		as_n_i   <= 1'b0;
		rw_i     <= 1'b0;
		// upper strobe high on case 3, so no write
		uds_n_i  <= (r[1:0] == 2'd3);
		vd8_i    <= r[9];
		zbak_n_i <= r[10];
		@(posedge MCLK);
		as_n_i  <= 1'b1;
		rw_i    <= 1'b1;
		uds_n_i <= 1'b1;
		if (r[1:0] != 2'd3 && pg == 16'ha111)
			busreq_m = r[9];
		if (r[1:0] != 2'd3 && pg == 16'ha112)
			zrun_m = r[9];
		@(negedge MCLK);
		check("zbr_n_o", 32'(zbr_n_o), 32'(!busreq_m));
		check("zres_n_o", 32'(zres_n_o), 32'(zrun_m));
		check("vd8_o", 32'(vd8_o), 32'(r[10]));
	endtask

	task automatic window_access;
		logic [31:0] r;
		logic [15:0] za;
		logic [22:0] exp_va;
		int          cnt;
		logic        seen;
		r  = $random(seed);
		za = {1'b1, r[14:0]};
		exp_va = {bank_m, za[14:1]};
		seen = 1'b0;
		cnt = 0;
		@(posedge MCLK);
		za_i    <= za;
		z_we_i  <= r[15];
		z_req_i <= 1'b1;
		as_n_i  <= 1'b1;
		zwr_n_i <= 1'b1;
		while (z_ack_o !== 1'b1 && cnt < 200)
		begin
			@(negedge MCLK);
			cnt = cnt + 1;
			if (!as_n_o)
			begin
				seen = 1'b1;
				check("va_o", 32'(va_o), 32'(exp_va));
				check("uds_n_o", 32'(uds_n_o), 32'(za[0]));
				check("lds_n_o", 32'(lds_n_o), 32'(!za[0]));
				check("rw_o", 32'(rw_o), 32'(!r[15]));
				check("br_n_o", 32'(br_n_o), 32'(1));
			end
		end
		if (cnt >= 200)
		begin
			to_cnt = to_cnt + 1;
			$display("timeout waiting for z_ack_o on window access at %0t", $time);
		end
		else if (!seen)
		begin
			err_cnt = err_cnt + 1;
			$display("window access acknowledged without a 68000 strobe at %0t", $time);
		end
		@(posedge MCLK);
		z_req_i <= 1'b0;
		cnt = 0;
		while (z_ack_o !== 1'b0 && cnt < 20)
		begin
			@(negedge MCLK);
			cnt = cnt + 1;
		end
		if (cnt >= 20)
		begin
			to_cnt = to_cnt + 1;
			$display("z_ack_o stayed high after the request was dropped at %0t", $time);
		end
	endtask

	initial
	begin
		logic [31:0] r;
		seed     = 32'h653c_e36a;
		err_cnt  = 0;
		chk_cnt  = 0;
		to_cnt   = 0;
		bank_m   = '0;
		busreq_m = 1'b0;
		zrun_m   = 1'b0;
		arst_n_i  <= 1'b0;
		va_i      <= '0;
		as_n_i    <= 1'b1;
		uds_n_i   <= 1'b1;
		rw_i      <= 1'b1;
		vd8_i     <= 1'b0;
		dtack_n_i <= 1'b1;
		bg_n_i    <= 1'b1;
		cart_i    <= 1'b0;
		za_i      <= '0;
		zwr_n_i   <= 1'b1;
		zd0_i     <= 1'b0;
		zbak_n_i  <= 1'b1;
		z_req_i   <= 1'b0;
		z_we_i    <= 1'b0;
		repeat (16) @(posedge MCLK);
		arst_n_i <= 1'b1;
		@(negedge MCLK);
		check("zbr_n_o", 32'(zbr_n_o), 32'(1));
		check("zres_n_o", 32'(zres_n_o), 32'(0));
		check("z_ack_o", 32'(z_ack_o), 32'(0));
		check("strobes", 32'({br_n_o, bgack_n_o, as_n_o, uds_n_o, lds_n_o}), 32'(5'h1f));

		for (int i = 0; i < 300; i++)
			decode_round();
		as_n_i <= 1'b1;
		for (int i = 0; i < 100; i++)
			ctrl_round();
		for (int i = 0; i < 40; i++)
		begin
			r = $random(seed);
			bank_load(1 + int'(r[3:0]));
			repeat (3) window_access();
		end

		$display("checks %0d errors %0d timeouts %0d", chk_cnt, err_cnt, to_cnt);
		if (err_cnt == 0 && to_cnt == 0)
		begin
			$display("TEST PASS");
		end
		else
		begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// last resort if a loop above never returns
	initial
	begin
		#2000000;
		$display("simulation ran past its time limit");
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* md_arbiter.f */
md_arbiter_pkg.sv
md_addr_decode.sv
md_z80_bank.sv
md_ctrl_regs.sv
md_bus_bridge.sv
md_arbiter.sv
tb_md_arbiter_assert.sv
tb_md_arbiter.sv

/* run_sim.sh */
#!/bin/sh
# build and run the arbiter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_md_arbiter \
	-f md_arbiter.f -o tb_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1

! grep -q "TEST FAIL" sim.log && grep -q "TEST PASS" sim.log \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed, see sim.log"; exit 1; }
